/* bench/tb_tiny32.sv */
`timescale 1ns/1ps

module tb_tiny32 import tiny32_pkg::*; ();

    logic            clk     = 1'b0;
    logic            nreset  = 1'b0;
    logic [XLEN-1:0] data_in = '0;
    logic            ready   = 1'b0;
    logic [XLEN-1:0] address;
    logic [XLEN-1:0] data_out;
    logic            nrd;
    logic [3:0]      nwr;
    logic            hlt;
    logic            error;

    logic [31:0] image [0:255];                                // Loaded into mem on reset.
    logic [31:0] mem [0:255];
    logic [31:0] exp_val [logic [31:0]];                       // Store address to value.
    logic [31:0] prog_pc;
    logic [11:0] store_off;
    logic [15:0] lfsr = 16'd50;
    logic [1:0]  wait_left = 2'd0;
    logic        busy = 1'b0;
    logic        active;
    int          store_errors = 0;
    int          stores_ok = 0;
    int          run_errors = 0;

    always #10 clk = ~clk;

    tiny32_core dut_i (
        .clk(clk), .nreset(nreset), .address(address), .data_in(data_in),
        .data_out(data_out), .nrd(nrd), .nwr(nwr), .ready(ready), .hlt(hlt), .error(error)
    );

    bind tiny32_core tiny32_asserts asserts_i (
        .clk(clk), .nreset(nreset), .address(address), .nrd(nrd), .nwr(nwr),
        .ready(ready), .hlt(hlt), .error(error)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // ------------------------------------------------------------------------
    // Memory model with random wait states
    // ------------------------------------------------------------------------
    assign active = !nrd || (nwr != WR_NONE);

    always @(posedge clk) begin
        logic [1:0] w;
        if (!nreset) begin
            for (int i = 0; i < 256; i++)
                mem[i] <= image[i];
            ready     <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 2'd0;
            stores_ok <= 0;
        end else begin
            data_in <= mem[address[9:2]];
            if (active && ready) begin                         // Transfer completes here.
                if (nwr == WR_WORD) begin
                    mem[address[9:2]] <= data_out;
                    if (!exp_val.exists(address)) begin
                        store_errors++;
                        $display("Unexpected store to address %h at %0t", address, $time);
                    end else if (data_out !== exp_val[address]) begin
                        store_errors++;
                        $display("CHECK FAILED at %0t: data_out @%h expected %h actual %h",
                                 $time, address, exp_val[address], data_out);
                    end else begin
                        stores_ok <= stores_ok + 1;
                    end
                end
                ready <= 1'b0;
                busy  <= 1'b0;
            end else if (active) begin
                if (!busy) begin
                    lfsr = lfsr_step(lfsr);
                    w[0] = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                    w[1] = lfsr[0];
                    if (w == 2'd3)
                        w = 2'd2;
                    busy      <= 1'b1;
                    ready     <= (w == 2'd0);
                    wait_left <= (w == 2'd0) ? 2'd0 : w - 2'd1;
                end else if (wait_left == 2'd0) begin
                    ready <= 1'b1;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Instruction encoding and program building
    // ------------------------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        image[prog_pc[9:2]] = word;
        prog_pc = prog_pc + 32'd4;
    endtask

    task automatic clear_image();
        logic [31:0] a;
        for (int i = 0; i < 256; i++) begin
            a = i * 4;
            image[i] = 32'hDEAD_0000 ^ a;                      // Tagged with the byte address.
        end
        prog_pc   = '0;
        store_off = '0;
        exp_val.delete();
    endtask

    task automatic store_expect(input logic [4:0] rs, input logic [31:0] value);
        emit(enc_s(store_off, rs, 5'd10));
        exp_val[32'h200 + {20'b0, store_off}] = value;
        store_off = store_off + 12'd4;
    endtask

    task automatic alu_r(input logic [2:0] f3, input logic [6:0] f7, input logic [31:0] v);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        store_expect(5'd3, v);
    endtask

    task automatic alu_i(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] v);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
        store_expect(5'd3, v);
    endtask

    // Taken path stores x12, fall-through stores x13, both into one slot.
    task automatic branch_check(input logic [31:0] first, input bit taken);
        emit(first);
        emit(enc_s(store_off, 5'd13, 5'd10));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_s(store_off, 5'd12, 5'd10));
        exp_val[32'h200 + {20'b0, store_off}] = taken ? 32'h111 : 32'h222;
        store_off = store_off + 12'd4;
    endtask

    task automatic build_program_a();
        logic [31:0] p;
        clear_image();
        emit(enc_i(12'hFF4, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));    // x1 = -12
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));      // x2 = 5
        emit(enc_i(12'h200, 5'd0, 3'd0, 5'd10, OPC_OP_IMM));   // Store base.
        emit(enc_i(12'h111, 5'd0, 3'd0, 5'd12, OPC_OP_IMM));
        emit(enc_i(12'h222, 5'd0, 3'd0, 5'd13, OPC_OP_IMM));
        alu_r(3'd0, 7'h00, 32'hFFFF_FFF9);
        alu_r(3'd0, 7'h20, 32'hFFFF_FFEF);
        alu_r(3'd1, 7'h00, 32'hFFFF_FE80);
        alu_r(3'd2, 7'h00, 32'h1);
        alu_r(3'd3, 7'h00, 32'h0);
        alu_r(3'd4, 7'h00, 32'hFFFF_FFF1);
        alu_r(3'd5, 7'h00, 32'h07FF_FFFF);
        alu_r(3'd5, 7'h20, 32'hFFFF_FFFF);
        alu_r(3'd6, 7'h00, 32'hFFFF_FFF5);
        alu_r(3'd7, 7'h00, 32'h4);
        alu_i(3'd0, 12'h005, 32'hFFFF_FFF9);
        alu_i(3'd1, 12'h005, 32'hFFFF_FE80);
        alu_i(3'd2, 12'h005, 32'h1);
        alu_i(3'd3, 12'h005, 32'h0);
        alu_i(3'd4, 12'h005, 32'hFFFF_FFF1);
        alu_i(3'd5, 12'h005, 32'h07FF_FFFF);
        alu_i(3'd5, 12'h405, 32'hFFFF_FFFF);
        alu_i(3'd6, 12'h005, 32'hFFFF_FFF5);
        alu_i(3'd7, 12'h005, 32'h4);
        emit({20'h12345, 5'd3, OPC_LUI});
        store_expect(5'd3, 32'h1234_5000);
        p = prog_pc;
        emit({20'h00001, 5'd3, OPC_AUIPC});
        store_expect(5'd3, p + 32'h1000);
        // x1 = -12, x2 = 5; each condition taken and not taken
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd0), 1'b0);
        branch_check(enc_b(13'd12, 5'd1, 5'd1, 3'd0), 1'b1);
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd1), 1'b1);
        branch_check(enc_b(13'd12, 5'd1, 5'd1, 3'd1), 1'b0);
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd4), 1'b1);
        branch_check(enc_b(13'd12, 5'd1, 5'd2, 3'd4), 1'b0);
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd5), 1'b0);
        branch_check(enc_b(13'd12, 5'd1, 5'd2, 3'd5), 1'b1);
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd6), 1'b0);
        branch_check(enc_b(13'd12, 5'd1, 5'd2, 3'd6), 1'b1);
        branch_check(enc_b(13'd12, 5'd2, 5'd1, 3'd7), 1'b1);
        branch_check(enc_b(13'd12, 5'd1, 5'd2, 3'd7), 1'b0);
        p = prog_pc;
        branch_check(enc_j(21'd12, 5'd5), 1'b1);
        store_expect(5'd5, p + 32'd4);                         // JAL link.
        p = prog_pc;
        emit({20'h00000, 5'd6, OPC_AUIPC});
        branch_check(enc_i(12'd16, 5'd6, 3'd0, 5'd7, OPC_JALR), 1'b1);
        store_expect(5'd7, p + 32'd8);                         // JALR link.
        image[8'hC0] = 32'h1234_5677;                          // Data word at 0x300.
        emit(enc_i(12'h100, 5'd10, 3'd2, 5'd8, OPC_LOAD));
        emit(enc_i(12'd1, 5'd8, 3'd0, 5'd8, OPC_OP_IMM));
        store_expect(5'd8, 32'h1234_5678);
        emit({17'b0, F3_HALT, 5'b0, OPC_CUSTOM});
    endtask

    task automatic build_program_b();
        clear_image();
        emit(enc_i(12'd2, 5'd0, 3'd2, 5'd1, OPC_LOAD));       // LW from address 2.
        emit({17'b0, F3_HALT, 5'b0, OPC_CUSTOM});
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nreset <= 1'b0;
        repeat (5) @(posedge clk);
        nreset <= 1'b1;
    endtask

    task automatic wait_flag(input bit want_error, input int limit);
        int n;
        n = 0;
        while (n < limit && !(want_error ? error : hlt)) begin
            @(posedge clk);
            n++;
        end
        if (!(want_error ? error : hlt)) begin
            run_errors++;
            $display("Timeout: %s never rose after %0d cycles", want_error ? "error" : "hlt",
                     limit);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int expected_stores;
        int total;
        build_program_a();
        expected_stores = exp_val.num();
        apply_reset();
        wait_flag(1'b0, 5000);
        repeat (10) @(posedge clk);
        if (error) begin
            run_errors++;
            $display("Error flag raised while running program A");
        end
        if (stores_ok != expected_stores) begin
            run_errors++;
            $display("Only %0d of %0d expected stores were seen", stores_ok, expected_stores);
        end

        build_program_b();
        apply_reset();
        wait_flag(1'b1, 500);
        repeat (10) @(posedge clk);
        if (hlt) begin
            run_errors++;
            $display("Halt reached after a misaligned load");
        end

        total = run_errors + store_errors + dut_i.asserts_i.fail_count;
        $display("Errors: run %0d, store %0d, assertion %0d", run_errors, store_errors,
                 dut_i.asserts_i.fail_count);
        if (total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* bench/tiny32_asserts.sv */
`timescale 1ns/1ps

module tiny32_asserts import tiny32_pkg::*; (
    input logic            clk,
    input logic            nreset,
    input logic [XLEN-1:0] address,
    input logic            nrd,
    input logic [3:0]      nwr,
    input logic            ready,
    input logic            hlt,
    input logic            error
);

    int   fail_count = 0;
    logic rd_seen;

    always_ff @(posedge clk) begin
        if (!nreset)
            rd_seen <= 1'b0;
        else if (!nrd)
            rd_seen <= 1'b1;                                   // First read is behind us.
    end

    // ------------------------------------------------------------------------
    // Bus protocol
    // ------------------------------------------------------------------------
    first_fetch: assert property (@(posedge clk) disable iff (!nreset)
        (!nrd && !rd_seen) |-> address == RESET_PC)
        else begin $error("First fetch not at reset PC"); fail_count++; end

    rd_held: assert property (@(posedge clk) disable iff (!nreset)
        (!nrd && !ready) |=> (!nrd && $stable(address)))
        else begin $error("Read strobe dropped before ready"); fail_count++; end

    wr_held: assert property (@(posedge clk) disable iff (!nreset)
        (nwr != WR_NONE && !ready) |=> (nwr == WR_WORD && $stable(address)))
        else begin $error("Write strobe dropped before ready"); fail_count++; end

    wr_idle_after_reset: assert property (@(posedge clk) disable iff (!nreset)
        !rd_seen |-> nwr == WR_NONE)
        else begin $error("Write strobe before the first fetch"); fail_count++; end

    no_overlap: assert property (@(posedge clk) disable iff (!nreset)
        !(!nrd && nwr != WR_NONE))
        else begin $error("Read and write strobes active together"); fail_count++; end

    // A misaligned access faults before any strobe.
    aligned_access: assert property (@(posedge clk) disable iff (!nreset)
        (!nrd || nwr != WR_NONE) |-> address[1:0] == 2'b00)
        else begin $error("Bus strobe at an unaligned address"); fail_count++; end

    // Sticky flags freeze the bus.
    halt_quiet: assert property (@(posedge clk) disable iff (!nreset)
        hlt |-> (nrd && nwr == WR_NONE))
        else begin $error("Bus strobe after halt"); fail_count++; end

    error_quiet: assert property (@(posedge clk) disable iff (!nreset)
        error |-> (nrd && nwr == WR_NONE))
        else begin $error("Bus strobe after error"); fail_count++; end

endmodule

/* flist.f */
hw/tiny32_pkg.sv
hw/decoded_if.sv
hw/phase_control.sv
hw/register_file.sv
hw/instr_decoder.sv
hw/execute_unit.sv
hw/tiny32_core.sv
bench/tiny32_asserts.sv
bench/tb_tiny32.sv

/* hw/decoded_if.sv */
`timescale 1ns/1ps

interface decoded_if import tiny32_pkg::*; ();

    instr_kind_t           kind;
    alu_op_t               alu_op;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;                                // Already sign extended.
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    modport producer (
        output kind,
        output alu_op,
        output funct3,
        output rd,
        output imm,
        output rs1_data,
        output rs2_data
    );

    modport consumer (
        input kind,
        input alu_op,
        input funct3,
        input rd,
        input imm,
        input rs1_data,
        input rs2_data
    );

endinterface

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import tiny32_pkg::*; (
    input  logic                  clk,
    input  phase_t                phase,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       data_in,
    decoded_if.consumer           dec,
    output logic [XLEN-1:0]       next_pc,
    output logic [XLEN-1:0]       mem_addr,
    output logic [XLEN-1:0]       store_data,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  halt_req,
    output logic                  fault,
    output logic                  we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] addr_sum;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] alu_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wb_q;
    logic            cond;
    logic            taken_q;

    assign op2      = (dec.kind == K_ALU) ? dec.rs2_data : dec.imm;
    assign addr_sum = dec.rs1_data + dec.imm;                  // Data address and JALR target.
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_res = dec.rs1_data - op2;
            ALU_SLL:  alu_res = dec.rs1_data << op2[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(dec.rs1_data) < $signed(op2)};
            ALU_SLTU: alu_res = {31'b0, dec.rs1_data < op2};
            ALU_XOR:  alu_res = dec.rs1_data ^ op2;
            ALU_SRL:  alu_res = dec.rs1_data >> op2[4:0];
            ALU_SRA:  alu_res = $signed(dec.rs1_data) >>> op2[4:0];
            ALU_OR:   alu_res = dec.rs1_data | op2;
            ALU_AND:  alu_res = dec.rs1_data & op2;
            default:  alu_res = dec.rs1_data + op2;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'd0:    cond = dec.rs1_data == dec.rs2_data;
            3'd1:    cond = dec.rs1_data != dec.rs2_data;
            3'd4:    cond = $signed(dec.rs1_data) < $signed(dec.rs2_data);
            3'd5:    cond = $signed(dec.rs1_data) >= $signed(dec.rs2_data);
            3'd6:    cond = dec.rs1_data < dec.rs2_data;
            3'd7:    cond = dec.rs1_data >= dec.rs2_data;
            default: cond = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Execute and memory phase registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (phase == PH_EXEC) begin
            alu_q   <= alu_res;
            taken_q <= cond;
            addr_q  <= addr_sum;
        end
        if (phase == PH_MEM) begin                             // Last load sample is on ready.
            case (dec.kind)
                K_LOAD:       wb_q <= data_in;
                K_LUI:        wb_q <= dec.imm;
                K_AUIPC:      wb_q <= pc + dec.imm;
                K_JAL, K_JALR: wb_q <= pc_plus4;
                default:      wb_q <= alu_q;
            endcase
        end
    end

    always_comb begin
        case (dec.kind)
            K_JAL:    next_pc = pc + dec.imm;
            K_JALR:   next_pc = {addr_q[XLEN-1:1], 1'b0};
            K_BRANCH: next_pc = taken_q ? pc + dec.imm : pc_plus4;
            default:  next_pc = pc_plus4;
        endcase
    end

    assign is_load  = dec.kind == K_LOAD;
    assign is_store = dec.kind == K_STORE;
    assign halt_req = (phase == PH_EXEC) && (dec.kind == K_HALT);
    assign fault    = (phase == PH_EXEC) && ((dec.kind == K_ILLEGAL) ||
                      ((is_load || is_store) && addr_sum[1:0] != 2'b00));

    assign we = dec.kind inside {K_ALU, K_ALU_IMM, K_LUI, K_AUIPC, K_JAL, K_JALR, K_LOAD};

    assign mem_addr   = addr_q;
    assign store_data = dec.rs2_data;
    assign wb_rd      = dec.rd;
    assign wb_data    = wb_q;

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import tiny32_pkg::*; (
    input  logic                  clk,
    input  logic                  nreset,
    input  phase_t                phase,
    input  logic                  ready,
    input  logic [XLEN-1:0]       data_in,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    decoded_if.producer           dec
);

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            latch;

    assign latch = (phase == PH_FETCH) && ready;
    assign rs1   = data_in[19:15];                             // Indexed straight off the bus.
    assign rs2   = data_in[24:20];

    always_ff @(posedge clk) begin
        if (!nreset)
            instr <= {25'b0, OPC_OP_IMM};                      // Decodes as a NOP.
        else if (latch)
            instr <= data_in;
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            rs1_q <= rs1_data;
            rs2_q <= rs2_data;
        end
    end

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // ------------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------------
    always_comb begin
        case (opcode)
            OPC_OP:     dec.kind = funct7[0] ? K_ILLEGAL : K_ALU;   // No M extension.
            OPC_OP_IMM: dec.kind = K_ALU_IMM;
            OPC_LUI:    dec.kind = K_LUI;
            OPC_AUIPC:  dec.kind = K_AUIPC;
            OPC_JAL:    dec.kind = K_JAL;
            OPC_JALR:   dec.kind = K_JALR;
            OPC_BRANCH: dec.kind = (funct3[2:1] == 2'b01) ? K_ILLEGAL : K_BRANCH;
            OPC_LOAD:   dec.kind = (funct3 == 3'd2) ? K_LOAD : K_ILLEGAL;
            OPC_STORE:  dec.kind = (funct3 == 3'd2) ? K_STORE : K_ILLEGAL;
            OPC_CUSTOM: dec.kind = (funct3 == F3_HALT) ? K_HALT : K_ILLEGAL;
            default:    dec.kind = K_ILLEGAL;
        endcase
    end

    always_comb begin
        case (funct3)
            3'd0:    dec.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    dec.alu_op = ALU_SLL;
            3'd2:    dec.alu_op = ALU_SLT;
            3'd3:    dec.alu_op = ALU_SLTU;
            3'd4:    dec.alu_op = ALU_XOR;
            3'd5:    dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    dec.alu_op = ALU_OR;
            default: dec.alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (dec.kind)
            K_ALU_IMM, K_JALR, K_LOAD: dec.imm = {{20{instr[31]}}, instr[31:20]};
            K_STORE:  dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            K_BRANCH: dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            K_LUI, K_AUIPC: dec.imm = {instr[31:12], 12'b0};
            K_JAL:    dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                 instr[30:21], 1'b0};
            default:  dec.imm = '0;
        endcase
    end

    assign dec.funct3   = funct3;
    assign dec.rd       = instr[11:7];
    assign dec.rs1_data = rs1_q;
    assign dec.rs2_data = rs2_q;

endmodule

/* hw/phase_control.sv */
`timescale 1ns/1ps

module phase_control import tiny32_pkg::*; (
    input  logic            clk,
    input  logic            nreset,
    input  logic            ready,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            halt_req,
    input  logic            fault,
    input  logic [XLEN-1:0] next_pc,
    output phase_t          phase,
    output logic [XLEN-1:0] pc,
    output logic            nrd,
    output logic            hlt,
    output logic            error
);

    logic stop;
    logic mem_access;
    logic advance;

    assign stop       = hlt | error;                           // Freezes the sequence.
    assign mem_access = is_load | is_store;

    always_comb begin
        case (phase)
            PH_FETCH: advance = ready;
            PH_EXEC:  advance = !halt_req && !fault;
            PH_MEM:   advance = !mem_access || ready;
            default:  advance = 1'b1;
        endcase
    end

    // ------------------------------------------------------------------------
    // Phase counter, PC and sticky flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!nreset) begin
            phase <= PH_WRITE;
            pc    <= RESET_PC;
            hlt   <= 1'b0;
            error <= 1'b0;
        end else if (!stop) begin
            if (halt_req)
                hlt <= 1'b1;
            if (fault)
                error <= 1'b1;
            if (advance) begin
                phase <= phase_t'(phase + 2'd1);               // MEM wraps to WRITE.
                if (phase == PH_MEM)
                    pc <= next_pc;
            end
        end
    end

    // Instruction fetch, or data read of a load
    assign nrd = stop || !(phase == PH_FETCH || (phase == PH_MEM && is_load));

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file import tiny32_pkg::*; (
    input  logic                  clk,
    input  phase_t                phase,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [0:31];                              // Entry 0 is never written.
    logic            write_en;

    assign write_en = (phase == PH_WRITE) && we && (rd != '0);

    always_ff @(posedge clk) begin
        if (write_en)
            regs[rd] <= wdata;
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/tiny32_core.sv */
`timescale 1ns/1ps

module tiny32_core import tiny32_pkg::*; (
    input  logic            clk,
    input  logic            nreset,
    output logic [XLEN-1:0] address,
    input  logic [XLEN-1:0] data_in,
    output logic [XLEN-1:0] data_out,
    output logic            nrd,
    output logic [3:0]      nwr,
    input  logic            ready,
    output logic            hlt,
    output logic            error
);

    phase_t                phase;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       next_pc;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       store_data;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       wb_data;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic                  is_load;
    logic                  is_store;
    logic                  halt_req;
    logic                  fault;
    logic                  we;
    logic                  data_phase;

    decoded_if dec_if ();

    phase_control phase_i (
        .clk(clk), .nreset(nreset), .ready(ready), .is_load(is_load), .is_store(is_store),
        .halt_req(halt_req), .fault(fault), .next_pc(next_pc), .phase(phase), .pc(pc),
        .nrd(nrd), .hlt(hlt), .error(error)
    );

    register_file regs_i (
        .clk(clk), .phase(phase), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .we(we), .rd(wb_rd), .wdata(wb_data)
    );

    instr_decoder decode_i (
        .clk(clk), .nreset(nreset), .phase(phase), .ready(ready), .data_in(data_in),
        .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data), .dec(dec_if)
    );

    execute_unit exec_i (
        .clk(clk), .phase(phase), .pc(pc), .data_in(data_in), .dec(dec_if),
        .next_pc(next_pc), .mem_addr(mem_addr), .store_data(store_data), .is_load(is_load),
        .is_store(is_store), .halt_req(halt_req), .fault(fault), .we(we), .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    // Data address only while a load or store owns the bus
    assign data_phase = (phase == PH_MEM) && (is_load || is_store);
    assign address    = data_phase ? mem_addr : pc;
    assign nwr        = (data_phase && is_store && !hlt && !error) ? WR_WORD : WR_NONE;
    assign data_out   = store_data;

endmodule

/* hw/tiny32_pkg.sv */
package tiny32_pkg;

    // ------------------------------------------------------------------------
    // Widths and reset values
    // ------------------------------------------------------------------------
    localparam int XLEN       = 32;                            // Data and address width.
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;     // First fetch address.

    localparam logic [3:0] WR_NONE = 4'b1111;                 // Write strobes idle.
    localparam logic [3:0] WR_WORD = 4'b0000;                 // All four byte lanes.

    // ------------------------------------------------------------------------
    // RV32I major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_LOAD   = 7'd3;
    localparam logic [6:0] OPC_CUSTOM = 7'd11;
    localparam logic [6:0] OPC_OP_IMM = 7'd19;
    localparam logic [6:0] OPC_AUIPC  = 7'd23;
    localparam logic [6:0] OPC_STORE  = 7'd35;
    localparam logic [6:0] OPC_OP     = 7'd51;
    localparam logic [6:0] OPC_LUI    = 7'd55;
    localparam logic [6:0] OPC_BRANCH = 7'd99;
    localparam logic [6:0] OPC_JALR   = 7'd103;
    localparam logic [6:0] OPC_JAL    = 7'd111;

    localparam logic [2:0] F3_HALT = 3'd2;                    // Under OPC_CUSTOM.

    typedef enum logic [1:0] {
        PH_WRITE,
        PH_FETCH,
        PH_EXEC,
        PH_MEM
    } phase_t;

    typedef enum logic [3:0] {
        K_ALU,
        K_ALU_IMM,
        K_LUI,
        K_AUIPC,
        K_JAL,
        K_JALR,
        K_BRANCH,
        K_LOAD,
        K_STORE,
        K_HALT,
        K_ILLEGAL
    } instr_kind_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
verilator --binary --timing --assert --top-module tb_tiny32 -f flist.f -o sim_tiny32 &&
./obj_dir/sim_tiny32 | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
